//--- mem_subsystem.f
logic/simplebus_pkg.sv
logic/simplebus_arbiter.sv
logic/simplebus2axi4.sv
logic/axi_sram.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_checker.sv
testbench/mem_subsystem_tb.sv

//--- Makefile
SIM = obj_dir/Vmem_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module mem_subsystem_tb \
		-f mem_subsystem.f --Mdir obj_dir

run: compile
	./$(SIM) +verilator+error+limit+100 2>&1 | tee run.log
	@grep -q "^NO ERRORS$$" run.log

clean:
	rm -rf obj_dir run.log

//--- testbench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;

    localparam int TXN_COUNT      = 258;
    localparam int TIMEOUT_CYCLES = TXN_COUNT * 40 + 200;
    localparam int WAIT_LIMIT     = 64;                        // Cycles per ready or complete.
    localparam int WINDOW_WORDS   = 32;
    localparam int RANDOM_OPS     = 200;
    localparam logic [31:0] WINDOW_BASE = 32'h0000_0BC0;      // Straddles PRIV_BASE.

    logic clk, rst;
    logic fetch_rd_req, fetch_rd_ready, fetch_rd_complete;
    logic data_rd_req, data_rd_ready, data_rd_complete;
    logic data_wr_req, data_wr_ready, data_wr_complete;
    simplebus_pkg::sb_rd_req_t fetch_rd, data_rd;
    simplebus_pkg::sb_rd_rsp_t fetch_rd_rsp, data_rd_rsp;
    simplebus_pkg::sb_wr_req_t data_wr;
    simplebus_pkg::sb_wr_rsp_t data_wr_rsp;

    logic [31:0] model_mem [simplebus_pkg::MEM_WORDS];
    logic [31:0] lfsr_state = 32'h9767b3a0;
    int errors = 0;
    int checks = 0;
    int test_base = 0;
    int cycle_count = 0;

    mem_subsystem DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing.", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};       // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic logic [1:0] expected_resp(input logic [31:0] addr,
                                                 input logic [2:0] size, input logic [2:0] prot);
        logic misaligned;
        case (size)
            3'd0:    misaligned = 1'b0;
            3'd1:    misaligned = addr[0];
            default: misaligned = (addr[1:0] != 2'b00);
        endcase
        if ((addr >> 2) >= 32'(simplebus_pkg::MEM_WORDS)) return simplebus_pkg::RESP_DECERR;
        if (misaligned) return simplebus_pkg::RESP_SLVERR;
        if (addr >= simplebus_pkg::PRIV_BASE && !prot[0]) return simplebus_pkg::RESP_SLVERR;
        return simplebus_pkg::RESP_OKAY;
    endfunction

    function automatic simplebus_pkg::sb_rd_rsp_t predict_read(
            input simplebus_pkg::sb_rd_req_t req);
        simplebus_pkg::sb_rd_rsp_t rsp;
        rsp.resp = expected_resp(req.addr, req.size, req.prot);
        rsp.data = '0;                                         // Failed reads return zero.
        if (rsp.resp == simplebus_pkg::RESP_OKAY) rsp.data = model_mem[req.addr[11:2]];
        return rsp;
    endfunction

    function automatic void merge_into_model(input simplebus_pkg::sb_wr_req_t req);
        if (expected_resp(req.addr, req.size, req.prot) != simplebus_pkg::RESP_OKAY) return;
        for (int i = 0; i < 4; i++) begin
            if (req.mask[i]) model_mem[req.addr[11:2]][8*i +: 8] = req.data[8*i +: 8];
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port drivers and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic do_read(input bit from_fetch, input simplebus_pkg::sb_rd_req_t req,
                           output simplebus_pkg::sb_rd_rsp_t rsp, output bit done);
        int waited;
        waited = 0;
        done = 1'b0;
        rsp = '0;
        @(negedge clk);
        while (!(from_fetch ? fetch_rd_ready : data_rd_ready)) begin
            if (waited == WAIT_LIMIT) begin
                $display("Read port (fetch=%0d) never became ready.", from_fetch);
                errors++;
                return;
            end
            @(negedge clk);
            waited++;
        end
        if (from_fetch) begin
            fetch_rd_req = 1'b1;
            fetch_rd     = req;
        end else begin
            data_rd_req = 1'b1;
            data_rd     = req;
        end
        @(negedge clk);
        fetch_rd_req = from_fetch ? 1'b0 : fetch_rd_req;
        data_rd_req  = from_fetch ? data_rd_req : 1'b0;
        waited = 0;
        while (!(from_fetch ? fetch_rd_complete : data_rd_complete)) begin
            if (waited == WAIT_LIMIT) begin
                $display("Read of %h (fetch=%0d) never completed.", req.addr, from_fetch);
                errors++;
                return;
            end
            @(negedge clk);
            waited++;
        end
        rsp = from_fetch ? fetch_rd_rsp : data_rd_rsp;
        done = 1'b1;
    endtask

    task automatic do_write(input simplebus_pkg::sb_wr_req_t req,
                            output simplebus_pkg::sb_wr_rsp_t rsp, output bit done);
        int waited;
        waited = 0;
        done = 1'b0;
        rsp = '0;
        @(negedge clk);
        while (!data_wr_ready) begin
            if (waited == WAIT_LIMIT) begin
                $display("Write port never became ready.");
                errors++;
                return;
            end
            @(negedge clk);
            waited++;
        end
        data_wr_req = 1'b1;
        data_wr     = req;
        @(negedge clk);
        data_wr_req = 1'b0;
        waited = 0;
        while (!data_wr_complete) begin
            if (waited == WAIT_LIMIT) begin
                $display("Write to %h never completed.", req.addr);
                errors++;
                return;
            end
            @(negedge clk);
            waited++;
        end
        rsp = data_wr_rsp;
        done = 1'b1;
    endtask

    task automatic check_rd_rsp(input string name, input simplebus_pkg::sb_rd_rsp_t got,
                                input simplebus_pkg::sb_rd_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got data=%h resp=%h, expected data=%h resp=%h",
                     name, got.data, got.resp, exp.data, exp.resp);
        end
    endtask

    task automatic check_wr_rsp(input string name, input simplebus_pkg::sb_wr_rsp_t got,
                                input simplebus_pkg::sb_wr_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got resp=%h, expected resp=%h", name, got.resp, exp.resp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic read_compare(input bit from_fetch, input logic [31:0] addr,
                                input logic [2:0] size, input logic [2:0] prot);
        simplebus_pkg::sb_rd_req_t req;
        simplebus_pkg::sb_rd_rsp_t got, exp;
        bit done;
        req.addr = addr;
        req.size = size;
        req.prot = prot;
        exp = predict_read(req);
        do_read(from_fetch, req, got, done);
        if (done && from_fetch) check_rd_rsp("fetch_rd_rsp", got, exp);
        else if (done) check_rd_rsp("data_rd_rsp", got, exp);
    endtask

    task automatic write_compare(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] mask, input logic [2:0] size,
                                 input logic [2:0] prot);
        simplebus_pkg::sb_wr_req_t req;
        simplebus_pkg::sb_wr_rsp_t got, exp;
        bit done;
        req.addr = addr;
        req.data = data;
        req.mask = mask;
        req.size = size;
        req.prot = prot;
        exp.resp = expected_resp(addr, size, prot);
        do_write(req, got, done);
        merge_into_model(req);
        if (done) check_wr_rsp("data_wr_rsp", got, exp);
    endtask

    task automatic start_test();
        test_base = errors;
    endtask

    task automatic end_of_test(input string name);
        $display("%-18s %0d errors", name, errors - test_base);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state();
        start_test();
        @(negedge clk);
        check_flag("fetch_rd_ready", fetch_rd_ready, 1'b1);
        check_flag("data_rd_ready", data_rd_ready, 1'b1);
        check_flag("data_wr_ready", data_wr_ready, 1'b1);
        repeat (8) begin
            @(negedge clk);
            check_flag("fetch_rd_complete", fetch_rd_complete, 1'b0);
            check_flag("data_rd_complete", data_rd_complete, 1'b0);
            check_flag("data_wr_complete", data_wr_complete, 1'b0);
        end
        end_of_test("reset state");
    endtask

    task automatic word_rw();
        start_test();
        write_compare(32'h040, 32'hDEAD_BEEF, 4'hF, 3'd2, 3'b000);
        read_compare(1'b0, 32'h040, 3'd2, 3'b000);
        read_compare(1'b1, 32'h040, 3'd2, 3'b100);
        end_of_test("word write/read");
    endtask

    task automatic byte_strobes();
        start_test();
        write_compare(32'h080, 32'h1122_3344, 4'hF, 3'd2, 3'b000);
        write_compare(32'h081, 32'h0000_AA00, 4'b0010, 3'd0, 3'b000);
        write_compare(32'h082, 32'hBBCC_0000, 4'b1100, 3'd1, 3'b000);
        read_compare(1'b0, 32'h080, 3'd2, 3'b000);
        write_compare(32'h084, 32'hCAFE_F00D, 4'hF, 3'd2, 3'b000);
        write_compare(32'h084, 32'h1234_5678, 4'b0101, 3'd2, 3'b000);
        read_compare(1'b0, 32'h084, 3'd2, 3'b000);
        end_of_test("byte strobes");
    endtask

    task automatic concurrent_ports();
        start_test();
        write_compare(32'h100, 32'h0BAD_F00D, 4'hF, 3'd2, 3'b000);
        write_compare(32'h104, 32'h600D_CAFE, 4'hF, 3'd2, 3'b000);
        fork
            read_compare(1'b1, 32'h100, 3'd2, 3'b100);
            read_compare(1'b0, 32'h104, 3'd2, 3'b000);
            write_compare(32'h108, 32'h7777_1111, 4'hF, 3'd2, 3'b000);
        join
        read_compare(1'b1, 32'h108, 3'd2, 3'b100);
        end_of_test("concurrent ports");
    endtask

    task automatic error_responses();
        start_test();
        write_compare(32'h000, 32'h1357_9BDF, 4'hF, 3'd2, 3'b000);
        write_compare(32'hC00, 32'h5A5A_A5A5, 4'hF, 3'd2, 3'b001);
        write_compare(32'h1000, 32'hFFFF_FFFF, 4'hF, 3'd2, 3'b001);
        read_compare(1'b0, 32'h1000, 3'd2, 3'b001);
        read_compare(1'b0, 32'h000, 3'd2, 3'b000);            // Word 0 shares the low index bits.
        write_compare(32'h041, 32'h00EE_EE00, 4'b0110, 3'd1, 3'b000);
        read_compare(1'b0, 32'h040, 3'd2, 3'b000);
        write_compare(32'hC00, 32'h0000_0000, 4'hF, 3'd2, 3'b000);
        read_compare(1'b0, 32'hC00, 3'd2, 3'b000);
        read_compare(1'b0, 32'hC00, 3'd2, 3'b001);
        end_of_test("error responses");
    endtask

    task automatic random_traffic();
        logic [31:0] pick, addr, data, size_bits, prot_bits, mask_bits;
        logic [2:0]  size;
        logic [3:0]  mask;
        start_test();
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            write_compare(WINDOW_BASE + 32'(4 * i), take_bits(32), 4'hF, 3'd2, 3'b001);
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick      = take_bits(2);
            addr      = WINDOW_BASE + take_bits(7);
            data      = take_bits(32);
            size_bits = take_bits(2);
            prot_bits = take_bits(1);
            mask_bits = take_bits(4);
            size = (size_bits[1:0] == 2'd3) ? 3'd2 : {1'b0, size_bits[1:0]};
            case (size)
                3'd0:    mask = 4'b0001 << addr[1:0];
                3'd1:    mask = 4'b0011 << addr[1:0];
                default: mask = mask_bits[3:0];
            endcase
            case (pick[1:0])
                2'd0:    read_compare(1'b1, addr, size, {2'b10, prot_bits[0]});
                2'd1:    read_compare(1'b0, addr, size, {2'b00, prot_bits[0]});
                default: write_compare(addr, data, mask, size, {2'b00, prot_bits[0]});
            endcase
        end
        end_of_test("random traffic");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst          = 1'b1;
        fetch_rd_req = 1'b0;
        data_rd_req  = 1'b0;
        data_wr_req  = 1'b0;
        fetch_rd     = '0;
        data_rd      = '0;
        data_wr      = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        reset_state();
        word_rw();
        byte_strobes();
        concurrent_ports();
        error_responses();
        random_traffic();

        errors += DUT.u_bridge.u_checker.fail_count;
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- testbench/mem_subsystem_checker.sv
`timescale 1ns/1ps

module mem_subsystem_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid,
    input  logic                   awready,
    input  simplebus_pkg::axi_ax_t aw,
    input  logic                   wvalid,
    input  logic                   arvalid,
    input  logic                   arready,
    input  simplebus_pkg::axi_ax_t ar,
    input  logic                   bvalid,
    input  logic                   bready,
    input  logic                   rvalid,
    input  logic                   rready,
    input  logic                   wr_complete,
    input  logic                   rd_complete
);

    int fail_count = 0;                                        // Number of assertion failures.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bridge AXI rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            fail_count++;
            $error("awvalid fell or aw changed before awready");
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            fail_count++;
            $error("arvalid fell or ar changed before arready");
        end

    w_after_aw: assert property (@(posedge clk) disable iff (rst)
        $rose(wvalid) |-> $past(awvalid && awready))
        else begin
            fail_count++;
            $error("wvalid rose without a preceding AW handshake");
        end

    // The response is taken one cycle after it appears, and completes right then.
    b_ready_complete: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bready && wr_complete)
        else begin
            fail_count++;
            $error("bready or wr_complete did not follow bvalid by one cycle");
        end

    r_ready_complete: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rready && rd_complete)
        else begin
            fail_count++;
            $error("rready or rd_complete did not follow rvalid by one cycle");
        end

endmodule

bind simplebus2axi4 mem_subsystem_checker u_checker (
    .clk(clk), .rst(rst),
    .awvalid(awvalid), .awready(awready), .aw(aw), .wvalid(wvalid),
    .arvalid(arvalid), .arready(arready), .ar(ar),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
    .wr_complete(wr_complete), .rd_complete(rd_complete)
);

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fetch_rd_req,
    input  simplebus_pkg::sb_rd_req_t  fetch_rd,
    output logic                       fetch_rd_ready,
    output logic                       fetch_rd_complete,
    output simplebus_pkg::sb_rd_rsp_t  fetch_rd_rsp,

    input  logic                       data_rd_req,
    input  simplebus_pkg::sb_rd_req_t  data_rd,
    output logic                       data_rd_ready,
    output logic                       data_rd_complete,
    output simplebus_pkg::sb_rd_rsp_t  data_rd_rsp,

    input  logic                       data_wr_req,
    input  simplebus_pkg::sb_wr_req_t  data_wr,
    output logic                       data_wr_ready,
    output logic                       data_wr_complete,
    output simplebus_pkg::sb_wr_rsp_t  data_wr_rsp
);

    // Arbiter to bridge.
    logic                      bus_rd_req, bus_rd_complete;
    logic                      bus_wr_req, bus_wr_complete;
    simplebus_pkg::sb_rd_req_t bus_rd;
    simplebus_pkg::sb_rd_rsp_t bus_rd_rsp;
    simplebus_pkg::sb_wr_req_t bus_wr;
    simplebus_pkg::sb_wr_rsp_t bus_wr_rsp;

    // Bridge to memory.
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    logic                   arvalid, arready, rvalid, rready;
    logic [1:0]             bresp;
    simplebus_pkg::axi_ax_t aw, ar;
    simplebus_pkg::axi_w_t  w;
    simplebus_pkg::axi_r_t  r;

    simplebus_arbiter u_arbiter (.*);

    simplebus2axi4 u_bridge (
        .clk, .rst,
        .rd_req(bus_rd_req), .rd(bus_rd), .rd_complete(bus_rd_complete), .rd_rsp(bus_rd_rsp),
        .wr_req(bus_wr_req), .wr(bus_wr), .wr_complete(bus_wr_complete), .wr_rsp(bus_wr_rsp),
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .bresp,
        .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

    axi_sram u_sram (
        .clk, .rst,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .bresp,
        .arvalid, .arready, .ar, .rvalid, .rready, .r
    );

endmodule

//--- logic/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       awvalid,
    output logic                       awready,
    input  simplebus_pkg::axi_ax_t     aw,

    input  logic                       wvalid,
    output logic                       wready,
    input  simplebus_pkg::axi_w_t      w,

    output logic                       bvalid,
    input  logic                       bready,
    output logic [1:0]                 bresp,

    input  logic                       arvalid,
    output logic                       arready,
    input  simplebus_pkg::axi_ax_t     ar,

    output logic                       rvalid,
    input  logic                       rready,
    output simplebus_pkg::axi_r_t      r
);

    logic [simplebus_pkg::DATA_WIDTH-1:0] mem [simplebus_pkg::MEM_WORDS];
    logic [15:0] lfsr;
    logic [1:0]  aw_cnt, w_cnt, ar_cnt;
    logic        aw_got, w_got, wr_fire;
    logic [1:0]  wr_chk, rd_chk;
    simplebus_pkg::axi_ax_t aw_q, aw_now;
    simplebus_pkg::axi_w_t  w_q, w_now;

    // Range first, then alignment and privilege.
    function automatic logic [1:0] check_access(simplebus_pkg::axi_ax_t ax);
        logic [simplebus_pkg::ADDR_WIDTH-1:0] align_mask;
        align_mask = (simplebus_pkg::ADDR_WIDTH'(1) << ax.size) - simplebus_pkg::ADDR_WIDTH'(1);
        if ((ax.addr >> 2) >= simplebus_pkg::ADDR_WIDTH'(simplebus_pkg::MEM_WORDS)) begin
            return simplebus_pkg::RESP_DECERR;
        end
        if ((ax.addr & align_mask) != '0) return simplebus_pkg::RESP_SLVERR;
        if (ax.addr >= simplebus_pkg::PRIV_BASE && !ax.prot[0]) begin
            return simplebus_pkg::RESP_SLVERR;
        end
        return simplebus_pkg::RESP_OKAY;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wait-state generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr   <= 16'hACE1;
            aw_cnt <= 2'd0;
            w_cnt  <= 2'd0;
            ar_cnt <= 2'd0;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            if (!awvalid || (awvalid && awready)) aw_cnt <= lfsr[1:0];
            else if (aw_cnt != 2'd0) aw_cnt <= aw_cnt - 2'd1;
            if (!wvalid || (wvalid && wready)) w_cnt <= lfsr[6:5];
            else if (w_cnt != 2'd0) w_cnt <= w_cnt - 2'd1;
            if (!arvalid || (arvalid && arready)) ar_cnt <= lfsr[11:10];
            else if (ar_cnt != 2'd0) ar_cnt <= ar_cnt - 2'd1;
        end
    end

    assign awready = !aw_got && !bvalid && (aw_cnt == 2'd0);
    assign wready  = !w_got && !bvalid && (w_cnt == 2'd0);
    assign arready = !rvalid && (ar_cnt == 2'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign aw_now  = aw_got ? aw_q : aw;
    assign w_now   = w_got ? w_q : w;
    assign wr_fire = (aw_got || (awvalid && awready)) && (w_got || (wvalid && wready));
    assign wr_chk  = check_access(aw_now);

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            aw_got <= !wr_fire && (aw_got || (awvalid && awready));
            w_got  <= !wr_fire && (w_got || (wvalid && wready));
            if (wr_fire) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;                   // Held until the master takes it.
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_q <= aw;
        if (wvalid && wready) w_q <= w;
        if (wr_fire) bresp <= wr_chk;
        if (wr_fire && wr_chk == simplebus_pkg::RESP_OKAY) begin
            for (int i = 0; i < simplebus_pkg::STRB_WIDTH; i++) begin
                if (w_now.strb[i]) begin
                    mem[aw_now.addr[simplebus_pkg::WORD_AW+1:2]][8*i +: 8] <= w_now.data[8*i +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_chk = check_access(ar);

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            r.resp <= rd_chk;
            r.data <= (rd_chk == simplebus_pkg::RESP_OKAY) ?
                      mem[ar.addr[simplebus_pkg::WORD_AW+1:2]] : '0;
        end
    end

endmodule

//--- logic/simplebus2axi4.sv
`timescale 1ns/1ps

module simplebus2axi4 (
    input  logic                       clk,
    input  logic                       rst,

    // Simple-bus side.
    input  logic                       rd_req,
    input  simplebus_pkg::sb_rd_req_t  rd,
    output logic                       rd_complete,
    output simplebus_pkg::sb_rd_rsp_t  rd_rsp,

    input  logic                       wr_req,
    input  simplebus_pkg::sb_wr_req_t  wr,
    output logic                       wr_complete,
    output simplebus_pkg::sb_wr_rsp_t  wr_rsp,

    // AXI write channels.
    output logic                       awvalid,
    input  logic                       awready,
    output simplebus_pkg::axi_ax_t     aw,

    output logic                       wvalid,
    input  logic                       wready,
    output simplebus_pkg::axi_w_t      w,

    input  logic                       bvalid,
    output logic                       bready,
    input  logic [1:0]                 bresp,

    // AXI read channels.
    output logic                       arvalid,
    input  logic                       arready,
    output simplebus_pkg::axi_ax_t     ar,

    input  logic                       rvalid,
    output logic                       rready,
    input  simplebus_pkg::axi_r_t      r
);

    logic aw_hs, w_hs, b_hs;
    logic ar_hs, r_hs;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
        end else if (wr_req) begin
            awvalid <= 1'b1;
        end else if (aw_hs) begin
            awvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req) aw <= '{addr: wr.addr, size: wr.size, prot: wr.prot};
    end

    // Data leaves only once the address has been taken.
    always_ff @(posedge clk) begin
        if (rst) begin
            wvalid <= 1'b0;
        end else if (aw_hs) begin
            wvalid <= 1'b1;
        end else if (w_hs) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) w <= '{data: wr.data, strb: wr.mask};       // Sender holds wr until done.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bready <= 1'b0;
        end else if (b_hs) begin
            bready <= 1'b0;
        end else if (bvalid) begin
            bready <= 1'b1;                                    // One cycle behind bvalid.
        end
    end

    assign wr_complete = b_hs;
    assign wr_rsp.resp = bresp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
        end else if (rd_req) begin
            arvalid <= 1'b1;
        end else if (ar_hs) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) ar <= '{addr: rd.addr, size: rd.size, prot: rd.prot};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rready <= 1'b0;
        end else if (r_hs) begin
            rready <= 1'b0;
        end else if (rvalid) begin
            rready <= 1'b1;
        end
    end

    assign rd_complete = r_hs;
    assign rd_rsp.data = r_hs ? r.data : '0;                   // Data is only meaningful here.
    assign rd_rsp.resp = r.resp;

endmodule

//--- logic/simplebus_arbiter.sv
`timescale 1ns/1ps

module simplebus_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       fetch_rd_req,
    input  simplebus_pkg::sb_rd_req_t  fetch_rd,
    output logic                       fetch_rd_ready,
    output logic                       fetch_rd_complete,
    output simplebus_pkg::sb_rd_rsp_t  fetch_rd_rsp,

    input  logic                       data_rd_req,
    input  simplebus_pkg::sb_rd_req_t  data_rd,
    output logic                       data_rd_ready,
    output logic                       data_rd_complete,
    output simplebus_pkg::sb_rd_rsp_t  data_rd_rsp,

    input  logic                       data_wr_req,
    input  simplebus_pkg::sb_wr_req_t  data_wr,
    output logic                       data_wr_ready,
    output logic                       data_wr_complete,
    output simplebus_pkg::sb_wr_rsp_t  data_wr_rsp,

    output logic                       bus_rd_req,
    output simplebus_pkg::sb_rd_req_t  bus_rd,
    input  logic                       bus_rd_complete,
    input  simplebus_pkg::sb_rd_rsp_t  bus_rd_rsp,

    output logic                       bus_wr_req,
    output simplebus_pkg::sb_wr_req_t  bus_wr,
    input  logic                       bus_wr_complete,
    input  simplebus_pkg::sb_wr_rsp_t  bus_wr_rsp
);

    logic rd_busy, rd_owner_data;
    logic data_pend, fetch_pend;
    logic data_take, fetch_take, data_want, fetch_want;
    logic rd_free, issue_data, issue_fetch;
    logic wr_busy, wr_take;
    simplebus_pkg::sb_rd_req_t data_hold, fetch_hold;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign data_rd_ready  = !data_pend && !(rd_busy && rd_owner_data);
    assign fetch_rd_ready = !fetch_pend && !(rd_busy && !rd_owner_data);
    assign data_take  = data_rd_req && data_rd_ready;
    assign fetch_take = fetch_rd_req && fetch_rd_ready;
    assign data_want  = data_take || data_pend;
    assign fetch_want = fetch_take || fetch_pend;
    assign rd_free     = !rd_busy || bus_rd_complete;          // Slot frees in the completion cycle.
    assign issue_data  = rd_free && data_want;                 // Data port has priority.
    assign issue_fetch = rd_free && fetch_want && !data_want;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy       <= 1'b0;
            rd_owner_data <= 1'b0;
            bus_rd_req    <= 1'b0;
            data_pend     <= 1'b0;
            fetch_pend    <= 1'b0;
        end else begin
            bus_rd_req <= issue_data || issue_fetch;
            data_pend  <= data_want && !issue_data;
            fetch_pend <= fetch_want && !issue_fetch;
            if (issue_data || issue_fetch) begin
                rd_busy       <= 1'b1;
                rd_owner_data <= issue_data;
            end else if (bus_rd_complete) begin
                rd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_take) data_hold <= data_rd;
        if (fetch_take) fetch_hold <= fetch_rd;
        if (issue_data) begin
            bus_rd <= data_pend ? data_hold : data_rd;
        end else if (issue_fetch) begin
            bus_rd <= fetch_pend ? fetch_hold : fetch_rd;
        end
    end

    assign data_rd_complete  = bus_rd_complete && rd_owner_data;
    assign fetch_rd_complete = bus_rd_complete && !rd_owner_data;
    assign data_rd_rsp  = data_rd_complete ? bus_rd_rsp : '0;
    assign fetch_rd_rsp = fetch_rd_complete ? bus_rd_rsp : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign data_wr_ready = !wr_busy;
    assign wr_take       = data_wr_req && !wr_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_busy    <= 1'b0;
            bus_wr_req <= 1'b0;
        end else begin
            bus_wr_req <= wr_take;
            if (wr_take) wr_busy <= 1'b1;
            else if (bus_wr_complete) wr_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) bus_wr <= data_wr;                        // Held until B returns.
    end

    assign data_wr_complete = bus_wr_complete;
    assign data_wr_rsp      = bus_wr_rsp;

endmodule

//--- logic/simplebus_pkg.sv
package simplebus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus geometry and memory map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int MEM_WORDS  = 1024;
    localparam int WORD_AW    = $clog2(MEM_WORDS);             // Word index bits.

    localparam logic [ADDR_WIDTH-1:0] PRIV_BASE = 32'h0000_0C00;  // Needs prot[0] above here.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Simple-bus requests and responses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            size;                           // Log2 of the byte count.
        logic [2:0]            prot;
    } sb_rd_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] mask;                           // One bit per byte lane.
        logic [2:0]            size;
        logic [2:0]            prot;
    } sb_wr_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } sb_rd_rsp_t;

    typedef struct packed {
        logic [1:0] resp;
    } sb_wr_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI4 single-beat channel payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            size;
        logic [2:0]            prot;
    } axi_ax_t;                                                // Shared by AW and AR.

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } axi_r_t;

endpackage
